/* verilog.f */
+incdir+design
design/mem_access_pkg.sv
design/data_memory_interface.sv
design/data_ram.sv
design/data_mem_subsystem.sv
tests/data_mem_checker.sv
tests/data_mem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the data memory testbench with Verilator and runs it.
# The exit status is zero only when the run reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module data_mem_tb \
    -Mdir obj_dir -o data_mem_sim \
    || { echo "build failed"; exit 1; }

sim_output="$(./obj_dir/data_mem_sim)"
echo "$sim_output"

grep -q "RESULT: PASS" <<< "$sim_output" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/data_mem_tb.sv */
// ==========================================================================
// Testbench top for the data memory subsystem: clock and reset, xorshift
// store data, the stimulus table and the loop that applies it.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "mem_access_macros.svh"

module data_mem_tb;

    typedef enum logic {op_load, op_store} op_e;

    // One row of the stimulus table.
    typedef struct packed {
        op_e                            op;
        mem_access_pkg::access_format_e format;
        logic [`MEM_ADDR_WIDTH-1:0]     address;
        logic [3:0]                     gap;          // Idle cycles before the access.
        logic                           random_data;  // Store data from the generator.
        logic [`MEM_DATA_WIDTH-1:0]     data;         // Fixed store data otherwise.
    } step_t;

    logic                           clock;
    logic                           reset;
    logic                           read_enable;
    logic                           write_enable;
    mem_access_pkg::access_format_e format;
    logic [`MEM_ADDR_WIDTH-1:0]     address;
    logic [`MEM_DATA_WIDTH-1:0]     write_data;
    logic [`MEM_DATA_WIDTH-1:0]     read_data;
    logic                           data_available;

    int          checked_count;
    int          pass_count;
    int          fail_count;
    step_t       steps [$];
    logic [31:0] random_state;
    int          cycle_count = 0;
    int          cycle_limit = 0;   // Set once the table is built.

    data_mem_subsystem dut (
        .clock          (clock),
        .reset          (reset),
        .read_enable    (read_enable),
        .write_enable   (write_enable),
        .format         (format),
        .address        (address),
        .write_data     (write_data),
        .read_data      (read_data),
        .data_available (data_available)
    );

    data_mem_checker u_checker (
        .clock          (clock),
        .reset          (reset),
        .read_enable    (read_enable),
        .write_enable   (write_enable),
        .format         (format),
        .address        (address),
        .write_data     (write_data),
        .read_data      (read_data),
        .data_available (data_available),
        .checked_count  (checked_count),
        .pass_count     (pass_count),
        .fail_count     (fail_count)
    );

    always #20 clock = ~clock;  // 40 ns period.

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic add_step(input op_e op, input mem_access_pkg::access_format_e fmt,
                            input logic [`MEM_ADDR_WIDTH-1:0] addr, input int gap,
                            input logic random_data, input logic [`MEM_DATA_WIDTH-1:0] data);
        step_t step;
        step.op          = op;
        step.format      = fmt;
        step.address     = addr;
        step.gap         = 4'(gap);
        step.random_data = random_data;
        step.data        = data;
        steps.push_back(step);
    endtask

    task automatic build_table();
        // Whole words, including one address that wraps past the RAM end.
        add_step(op_store, mem_access_pkg::fmt_word,   32'h0000_0000, 2, 1'b1, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_word,   32'h0000_0004, 0, 1'b1, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_word,   32'h0000_03fc, 0, 1'b1, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_word,   32'h0000_0100, 0, 1'b1, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_word,   32'h0000_0000, 2, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_word,   32'h0000_0004, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_word,   32'h0000_03fc, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_word,   32'h0000_0404, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_word,   32'h0000_0100, 0, 1'b0, 32'h0);
        // Partial stores at every offset, read back as whole words.
        add_step(op_store, mem_access_pkg::fmt_word,   32'h0000_0010, 0, 1'b1, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_byte,   32'h0000_0011, 0, 1'b1, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_word,   32'h0000_0010, 0, 1'b0, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_byte,   32'h0000_0010, 0, 1'b1, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_byte_u, 32'h0000_0013, 0, 1'b1, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_byte,   32'h0000_0012, 0, 1'b1, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_word,   32'h0000_0010, 0, 1'b0, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_word,   32'h0000_0020, 1, 1'b1, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_half,   32'h0000_0020, 0, 1'b1, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_half,   32'h0000_0021, 0, 1'b1, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_word,   32'h0000_0020, 0, 1'b0, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_half_u, 32'h0000_0022, 0, 1'b1, 32'h0);
        add_step(op_store, mem_access_pkg::fmt_half,   32'h0000_0023, 0, 1'b1, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_word,   32'h0000_0020, 0, 1'b0, 32'h0);
        // Sign and zero extension, with top bits both set and clear.
        add_step(op_store, mem_access_pkg::fmt_word,   32'h0000_0040, 2, 1'b0, 32'h80ff_7f01);
        add_step(op_store, mem_access_pkg::fmt_word,   32'h0000_0044, 0, 1'b0, 32'h7f80_ff00);
        add_step(op_load,  mem_access_pkg::fmt_byte,   32'h0000_0040, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_byte,   32'h0000_0041, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_byte,   32'h0000_0042, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_byte,   32'h0000_0043, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_byte_u, 32'h0000_0042, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_byte_u, 32'h0000_0043, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_byte_u, 32'h0000_0040, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_half,   32'h0000_0040, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_half,   32'h0000_0042, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_half_u, 32'h0000_0042, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_half_u, 32'h0000_0040, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_byte,   32'h0000_0045, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_byte_u, 32'h0000_0045, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_half,   32'h0000_0044, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_half_u, 32'h0000_0044, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_half,   32'h0000_0046, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_half,   32'h0000_0041, 0, 1'b0, 32'h0);
        add_step(op_load,  mem_access_pkg::fmt_half_u, 32'h0000_0043, 0, 1'b0, 32'h0);
    endtask

    // Called right after a falling edge.
    task automatic drive_step(input step_t step);
        if (step.op == op_store) begin
            if (step.random_data) begin
                random_state = next_random(random_state);
                write_data   = random_state;
            end else begin
                write_data = step.data;
            end
            read_enable  = 1'b0;
            write_enable = 1'b1;
        end else begin
            write_data   = '0;
            write_enable = 1'b0;
            read_enable  = 1'b1;
        end
        format  = step.format;
        address = step.address;
    endtask

    task automatic wait_for_completion();
        @(negedge clock);
        while (!data_available) @(negedge clock);
    endtask

    initial begin
        clock        = 1'b0;
        reset        = 1'b1;
        read_enable  = 1'b0;
        write_enable = 1'b0;
        format       = mem_access_pkg::fmt_word;
        address      = '0;
        write_data   = '0;
        random_state = 32'hdc2b745c;
        build_table();
        cycle_limit = steps.size() * (`MEM_WAIT_CYCLES + 3) + 50;
        repeat (4) @(negedge clock);
        reset = 1'b0;
        repeat (5) @(negedge clock);  // No access yet, so no data_available either.
        foreach (steps[i]) begin
            if (steps[i].gap != 0) begin
                @(negedge clock);
                read_enable  = 1'b0;
                write_enable = 1'b0;
                repeat (int'(steps[i].gap) - 1) @(negedge clock);
            end
            @(negedge clock);  // With no gap this is the cycle after data_available.
            drive_step(steps[i]);
            wait_for_completion();
        end
        @(negedge clock);
        read_enable  = 1'b0;
        write_enable = 1'b0;
        repeat (4) @(negedge clock);
        if (checked_count != steps.size()) begin
            $display("error: only %0d of %0d accesses completed", checked_count, steps.size());
        end
        $display("accesses checked: %0d, passed: %0d, failed: %0d",
                 checked_count, pass_count, fail_count);
        if (fail_count == 0 && checked_count == steps.size()) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/data_mem_checker.sv */
// ==========================================================================
// Checker for the data memory subsystem: byte-array model of the RAM,
// load value and latency comparison, and pass and fail counters.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "mem_access_macros.svh"

module data_mem_checker (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           read_enable,
    input  logic                           write_enable,
    input  mem_access_pkg::access_format_e format,
    input  logic [`MEM_ADDR_WIDTH-1:0]     address,
    input  logic [`MEM_DATA_WIDTH-1:0]     write_data,
    input  logic [`MEM_DATA_WIDTH-1:0]     read_data,
    input  logic                           data_available,
    output int                             checked_count,
    output int                             pass_count,
    output int                             fail_count
);

    localparam int MODEL_BYTES = `MEM_DEPTH_WORDS * 4;
    localparam int LATENCY     = `MEM_WAIT_CYCLES + 1;

    logic [7:0] model_bytes [MODEL_BYTES];  // One entry per RAM byte.

    logic                           pending;          // An access is in flight.
    logic                           pending_store;
    mem_access_pkg::access_format_e pending_format;
    logic [`MEM_ADDR_WIDTH-1:0]     pending_address;
    logic [`MEM_DATA_WIDTH-1:0]     pending_data;
    int                             cycles;           // Edges since the enable was seen.

    initial begin
        checked_count = 0;
        pass_count    = 0;
        fail_count    = 0;
        pending       = 1'b0;
        cycles        = 0;
    end

    // Index of lane 0 of the addressed word, wrapped to the RAM size.
    function automatic int word_base(input logic [`MEM_ADDR_WIDTH-1:0] addr);
        return int'({2'b00, addr[`MEM_ADDR_WIDTH-1:2]} % `MEM_DEPTH_WORDS) * 4;
    endfunction

    // Number of bytes an access of this format moves.
    function automatic int access_bytes(input logic [2:0] code);
        case (code[1:0])
            2'b00:   return 1;
            2'b01:   return 2;
            2'b10:   return 4;
            default: return 0;
        endcase
    endfunction

    task automatic apply_store(input logic [`MEM_ADDR_WIDTH-1:0] addr,
                               input logic [2:0] code,
                               input logic [`MEM_DATA_WIDTH-1:0] data);
        int base;
        int offset;
        base   = word_base(addr);
        offset = int'(addr[1:0]);
        for (int i = 0; i < access_bytes(code); i++) begin
            if (offset + i < 4) begin  // Lanes past the word end are lost.
                model_bytes[base + offset + i] = data[8*i +: 8];
            end
        end
    endtask

    function automatic logic [`MEM_DATA_WIDTH-1:0] expected_load(
            input logic [`MEM_ADDR_WIDTH-1:0] addr, input logic [2:0] code);
        logic [`MEM_DATA_WIDTH-1:0] word;
        logic [`MEM_DATA_WIDTH-1:0] shifted;
        logic [`MEM_DATA_WIDTH-1:0] value;
        int                         base;
        base = word_base(addr);
        for (int i = 0; i < 4; i++) begin
            word[8*i +: 8] = model_bytes[base + i];
        end
        shifted = word >> (8 * int'(addr[1:0]));
        value   = '0;
        if (code[1:0] == 2'b00) begin
            value[7:0] = shifted[7:0];
            if (!code[2] && shifted[7]) value[`MEM_DATA_WIDTH-1:8] = '1;
        end else if (code[1:0] == 2'b01) begin
            value[15:0] = shifted[15:0];
            if (!code[2] && shifted[15]) value[`MEM_DATA_WIDTH-1:16] = '1;
        end else if (code[1:0] == 2'b10) begin
            value = shifted;
        end
        return value;
    endfunction

    task automatic finish_access();
        logic [`MEM_DATA_WIDTH-1:0] expected;
        logic                       ok;
        ok = 1'b1;
        checked_count++;
        if (cycles != LATENCY) begin
            $display("mismatch at %0t: test %0d latency expected %0d cycles, observed %0d",
                     $time, checked_count, LATENCY, cycles);
            ok = 1'b0;
        end
        if (pending_store) begin
            apply_store(pending_address, pending_format, pending_data);
        end else begin
            expected = expected_load(pending_address, pending_format);
            if (read_data !== expected) begin
                $display("mismatch at %0t: test %0d %s load at %h expected %h, observed %h",
                         $time, checked_count, pending_format.name(), pending_address,
                         expected, read_data);
                ok = 1'b0;
            end
        end
        if (ok) begin
            pass_count++;
            $display("test %0d: %s %s at %h passed", checked_count,
                     pending_store ? "store" : "load", pending_format.name(), pending_address);
        end else begin
            fail_count++;
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            pending = 1'b0;
            cycles  = 0;
        end else if (pending) begin
            cycles++;
            if (data_available) begin
                finish_access();
                pending = 1'b0;
            end
        end else if (data_available) begin
            $display("error at %0t: data_available pulsed with no access in progress",
                     $time);  // Also catches a second pulse for one access.
            fail_count++;
        end else if (read_enable || write_enable) begin
            pending         = 1'b1;
            cycles          = 0;
            pending_store   = write_enable;
            pending_format  = format;
            pending_address = address;
            pending_data    = write_data;
        end
    end

endmodule

`default_nettype wire

/* design/data_mem_subsystem.sv */
// ==========================================================================
// Data memory subsystem top: the core-side load/store ports, the data
// memory interface and the data RAM joined by one request/response bus.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "mem_access_macros.svh"

module data_mem_subsystem (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           read_enable,     // Held until data_available.
    input  logic                           write_enable,    // Held until data_available.
    input  mem_access_pkg::access_format_e format,
    input  logic [`MEM_ADDR_WIDTH-1:0]     address,
    input  logic [`MEM_DATA_WIDTH-1:0]     write_data,
    output logic [`MEM_DATA_WIDTH-1:0]     read_data,       // Valid with data_available.
    output logic                           data_available   // One-cycle completion pulse.
);

    // The data bus between the interface and the RAM.
    mem_access_pkg::bus_request_t  bus_request;
    mem_access_pkg::bus_response_t bus_response;

    data_memory_interface u_interface (
        .clock          (clock),
        .reset          (reset),
        .read_enable    (read_enable),
        .write_enable   (write_enable),
        .format         (format),
        .address        (address),
        .write_data     (write_data),
        .read_data      (read_data),
        .data_available (data_available),
        .bus_request    (bus_request),
        .bus_response   (bus_response)
    );

    data_ram u_ram (
        .clock        (clock),
        .reset        (reset),
        .bus_request  (bus_request),
        .bus_response (bus_response)
    );

endmodule

`default_nettype wire

/* design/data_ram.sv */
// ==========================================================================
// Byte-enabled word RAM on the wait-request/valid data bus. A small FSM
// holds wait_req for a fixed number of cycles, performs the access on
// acceptance and returns valid for one cycle.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "mem_access_macros.svh"

module data_ram (
    input  logic                          clock,
    input  logic                          reset,
    input  mem_access_pkg::bus_request_t  bus_request,
    output mem_access_pkg::bus_response_t bus_response
);

    localparam int COUNT_WIDTH = $clog2(`MEM_WAIT_CYCLES + 1);
    localparam int INDEX_WIDTH = $clog2(`MEM_DEPTH_WORDS);
    localparam int LANES       = `MEM_DATA_WIDTH / 8;

    mem_access_pkg::ram_state_e state;
    mem_access_pkg::ram_state_e next_state;

    logic [COUNT_WIDTH-1:0]     wait_count;    // Wait cycles already spent.
    logic                       request_seen;  // Either bus enable is high.
    logic                       wait_req;
    logic                       accept;        // Access is performed this cycle.
    logic [INDEX_WIDTH-1:0]     word_index;    // Word address inside the RAM.
    logic [`MEM_DATA_WIDTH-1:0] read_word;     // Word latched for the response.

    logic [`MEM_DATA_WIDTH-1:0] memory [`MEM_DEPTH_WORDS];

    assign request_seen = bus_request.read_enable || bus_request.write_enable;
    assign word_index   = bus_request.address[INDEX_WIDTH+1:2];

    // The first cycle of a request is spent in ram_idle, which is why the
    // counter starts at one when it enters ram_wait.
    always_comb begin
        case (state)
            mem_access_pkg::ram_idle: begin
                wait_req = request_seen;
            end
            mem_access_pkg::ram_wait: begin
                wait_req = wait_count < COUNT_WIDTH'(`MEM_WAIT_CYCLES);
            end
            default: begin
                wait_req = 1'b0;
            end
        endcase
    end

    assign accept = (state == mem_access_pkg::ram_wait) && request_seen && !wait_req;

    always_comb begin
        next_state = state;
        case (state)
            mem_access_pkg::ram_idle: begin
                if (request_seen) begin
                    next_state = mem_access_pkg::ram_wait;
                end
            end
            mem_access_pkg::ram_wait: begin
                if (accept) begin
                    next_state = mem_access_pkg::ram_respond;
                end else if (!request_seen) begin
                    next_state = mem_access_pkg::ram_idle;  // Request withdrawn.
                end
            end
            mem_access_pkg::ram_respond: begin
                next_state = mem_access_pkg::ram_idle;  // Valid lasts one cycle.
            end
            default: begin
                next_state = mem_access_pkg::ram_idle;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= mem_access_pkg::ram_idle;
            wait_count <= '0;
        end else begin
            state <= next_state;
            if (state == mem_access_pkg::ram_idle) begin
                wait_count <= COUNT_WIDTH'(1);
            end else if (wait_req) begin
                wait_count <= wait_count + 1'b1;
            end
        end
    end

    // Storage and the read latch.
    always_ff @(posedge clock) begin
        if (accept && bus_request.write_enable) begin
            for (int lane = 0; lane < LANES; lane++) begin
                if (bus_request.byte_enable[lane]) begin
                    memory[word_index][8*lane +: 8] <= bus_request.write_data[8*lane +: 8];
                end
            end
        end
        if (accept && bus_request.read_enable) begin
            read_word <= memory[word_index];  // Whole word, lanes sorted out upstream.
        end
    end

    assign bus_response.read_data = read_word;
    assign bus_response.wait_req  = wait_req;
    assign bus_response.valid     = (state == mem_access_pkg::ram_respond);

    // A request held off by wait_req stays unchanged until the RAM takes it.
    a_request_held: assert property (@(posedge clock) disable iff (reset)
        request_seen && wait_req |=> $stable(bus_request));

endmodule

`default_nettype wire

/* design/data_memory_interface.sv */
// ==========================================================================
// Data memory interface between the core's execute stage and the data bus:
// store lane steering, byte enables, load realignment and extension, and
// the tracker that allows one bus request per access.
// ==========================================================================

`timescale 1ns/1ps
`default_nettype none

`include "mem_access_macros.svh"

module data_memory_interface (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           read_enable,
    input  logic                           write_enable,
    input  mem_access_pkg::access_format_e format,
    input  logic [`MEM_ADDR_WIDTH-1:0]     address,
    input  logic [`MEM_DATA_WIDTH-1:0]     write_data,
    output logic [`MEM_DATA_WIDTH-1:0]     read_data,
    output logic                           data_available,
    output mem_access_pkg::bus_request_t   bus_request,
    input  mem_access_pkg::bus_response_t  bus_response
);

    logic [2:0]                 format_code;   // Raw encoding of the format.
    logic [1:0]                 byte_offset;   // Byte lane of the address.
    logic [4:0]                 shift_bits;    // Byte offset in bits.
    logic                       sign_load;     // Extend from the top loaded bit.
    logic                       request_sent;  // Bus request accepted, awaiting valid.
    logic                       accept;        // Request taken by the RAM this cycle.
    logic [`MEM_DATA_WIDTH-1:0] shifted_read;  // Returned word moved down to lane 0.

    assign format_code = format;
    assign byte_offset = address[1:0];
    assign shift_bits  = {byte_offset, 3'b000};
    assign sign_load   = !format_code[2];

    // The core holds its enable for the whole access, so the enables are
    // masked once the RAM has taken the request.
    assign bus_request.address      = address;
    assign bus_request.write_data   = write_data << shift_bits;
    assign bus_request.read_enable  = read_enable && !request_sent;
    assign bus_request.write_enable = write_enable && !request_sent;

    // Lanes past the top of the word are dropped by the 4-bit result.
    always_comb begin
        case (format_code[1:0])
            2'b00:   bus_request.byte_enable = 4'b0001 << byte_offset;
            2'b01:   bus_request.byte_enable = 4'b0011 << byte_offset;
            2'b10:   bus_request.byte_enable = 4'b1111 << byte_offset;
            default: bus_request.byte_enable = 4'b0000;
        endcase
    end

    assign shifted_read = bus_response.read_data >> shift_bits;

    always_comb begin
        case (format_code[1:0])
            2'b00: begin
                read_data = {{(`MEM_DATA_WIDTH-8){sign_load & shifted_read[7]}},
                             shifted_read[7:0]};
            end
            2'b01: begin
                read_data = {{(`MEM_DATA_WIDTH-16){sign_load & shifted_read[15]}},
                             shifted_read[15:0]};
            end
            2'b10:   read_data = shifted_read;
            default: read_data = '0;  // Reserved size returns nothing.
        endcase
    end

    assign data_available = bus_response.valid;

    assign accept = (bus_request.read_enable || bus_request.write_enable)
                    && !bus_response.wait_req;

    always_ff @(posedge clock) begin
        if (reset) begin
            request_sent <= 1'b0;
        end else if (bus_response.valid) begin
            request_sent <= 1'b0;  // Access done, the next one may go out.
        end else if (accept) begin
            request_sent <= 1'b1;
        end
    end

    // The core never asks for a load and a store at once.
    a_single_direction: assert property (@(posedge clock) disable iff (reset)
        !(bus_request.read_enable && bus_request.write_enable));

    // After acceptance the RAM answers in the next cycle, and no second
    // request leaves the interface while that answer is pending.
    a_one_request: assert property (@(posedge clock) disable iff (reset)
        accept |=> bus_response.valid
                   && !(bus_request.read_enable || bus_request.write_enable));

endmodule

`default_nettype wire

/* design/mem_access_pkg.sv */
// ==========================================================================
// Shared types for the load/store path: access format and RAM state enums,
// and the request and response structs of the data bus.
// ==========================================================================

`default_nettype none

`include "mem_access_macros.svh"

package mem_access_pkg;

    // Bit 2 marks an unsigned load, bits 1:0 give the access size.
    typedef enum logic [2:0] {
        fmt_byte   = 3'd0,  // Signed byte.
        fmt_half   = 3'd1,  // Signed halfword.
        fmt_word   = 3'd2,  // Full word.
        fmt_byte_u = 3'd4,  // Unsigned byte.
        fmt_half_u = 3'd5   // Unsigned halfword.
    } access_format_e;

    // Controller states of the data RAM.
    typedef enum logic [1:0] {
        ram_idle,     // No access in progress.
        ram_wait,     // Counting wait states.
        ram_respond   // Valid is high for this one cycle.
    } ram_state_e;

    // Request from the memory interface to the RAM.
    typedef struct packed {
        logic [`MEM_ADDR_WIDTH-1:0] address;
        logic [`MEM_DATA_WIDTH-1:0] write_data;   // Already steered into its lanes.
        logic [3:0]                 byte_enable;  // One bit per byte lane.
        logic                       read_enable;
        logic                       write_enable;
    } bus_request_t;

    // Response from the RAM back to the memory interface.
    typedef struct packed {
        logic [`MEM_DATA_WIDTH-1:0] read_data;  // Whole addressed word.
        logic                       wait_req;   // Request is not yet accepted.
        logic                       valid;      // One-cycle completion pulse.
    } bus_response_t;

endpackage

`default_nettype wire

/* design/mem_access_macros.svh */
// ==========================================================================
// Size constants for the data memory subsystem: word and address widths,
// RAM depth and the fixed number of RAM wait states.
// ==========================================================================

`ifndef MEM_ACCESS_MACROS_SVH
`define MEM_ACCESS_MACROS_SVH

// Width of one data word in bits.
`define MEM_DATA_WIDTH 32

// Width of a byte address in bits.
`define MEM_ADDR_WIDTH 32

// Number of words in the data RAM. Addresses wrap at four times this value.
`define MEM_DEPTH_WORDS 256

// Cycles that wait_req stays high after a request first appears.
// Must be at least 1.
`define MEM_WAIT_CYCLES 2

`endif
